/* flist.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/rob_pkg.sv
hdl/rob_dispatch.sv
hdl/rob_branch_queue.sv
hdl/rob_entry_table.sv
hdl/rob_commit.sv
hdl/rob_top.sv
verif/rob_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the reorder buffer testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f flist.f \
    --top-module rob_tb -o rob_sim ||
    { echo "run_sim: build failed"; exit 1; }

# pass only when the testbench printed its pass line
sim_out="$(./obj_dir/rob_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully" &&
    { echo "run_sim: pass"; exit 0; } ||
    { echo "run_sim: fail"; exit 1; }

/* verif/rob_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

    import isa_pkg::*;
    import rob_pkg::*;

    localparam int clk_period = 10;
    // cycles any single wait may take
    localparam int wait_limit = 200;
    localparam logic [31:0] lfsr_seed = 32'hf6ac3c3f;

    logic       clk;
    logic       rst;
    logic       alloc_valid;
    op_t        alloc_op;
    reg_idx_t   alloc_rd;
    reg_idx_t   alloc_st_src;
    logic       alloc_pred_taken;
    logic       alloc_ready;
    rob_tag_t   alloc_tag;
    logic       complete_valid;
    rob_tag_t   complete_tag;
    logic       br_update_valid;
    rob_tag_t   br_update_tag;
    logic       br_taken;
    logic       data_mem_resp;
    logic [1:0] mem_offset;
    logic       data_read;
    logic       data_write;
    logic [3:0] wmask;
    logic       regfile_load;
    logic       ld_commit_sel;
    reg_idx_t   rd_commit;
    logic       pc_redirect;
    logic       squash_busy;

    // reference queue with one slot per tag
    op_t        m_op [8];
    reg_idx_t   m_rd [8];
    logic       m_pred [8];
    logic       m_taken [8];
    logic       m_done [8];
    rob_tag_t   m_head;
    rob_tag_t   m_tail;
    logic [3:0] m_count;
    // redirect seen last cycle
    logic       m_mis_q;

    logic [31:0] lfsr;
    int          errors = 0;
    int          timeouts = 0;
    int          allocs;
    int          retired;

    // expected behavior of the head slot
    op_t        head_op;
    logic       head_ready;
    logic       head_is_load;
    logic       head_is_store;
    logic       accept;
    logic       exp_retire;
    logic       exp_reg_load;
    logic       exp_mispredict;
    logic       exp_ready;
    logic [3:0] exp_wmask;

    rob_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // bytes a store touches
    // SW always covers the whole word
    function automatic logic [3:0] byte_enables(input op_t op, input logic [1:0] off);
        logic [3:0] be;
        int         width;
        int         start;
        be = 4'b0000;
        start = (op == OP_SW) ? 0 : int'(off);
        case (op)
            OP_SW:   width = 4;
            OP_SH:   width = 2;
            OP_SB:   width = 1;
            default: width = 0;
        endcase
        for (int b = 0; b < 4; b++) begin
            be[b] = (b >= start) && (b < start + width);
        end
        return be;
    endfunction

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    assign head_op        = m_op[m_head];
    assign head_ready     = (m_count != 4'd0) && m_done[m_head];
    assign head_is_load   = head_op inside {OP_LW, OP_LH, OP_LB, OP_LBU, OP_LHU};
    assign head_is_store  = head_op inside {OP_SW, OP_SH, OP_SB};
    assign accept         = alloc_valid && alloc_ready;
    // memory ops wait for the cache and everything else goes at once
    assign exp_retire     = head_ready && (!(head_is_load || head_is_store) || data_mem_resp);
    assign exp_reg_load   = exp_retire && ((head_op == OP_ALU) || head_is_load);
    assign exp_mispredict = exp_retire && (head_op == OP_BRANCH)
                            && (m_taken[m_head] != m_pred[m_head]);
    assign exp_ready      = (m_count != 4'd8) && !squash_busy;
    assign exp_wmask      = byte_enables(head_op, mem_offset);

    always @(posedge clk) begin
        if (rst) begin
            m_head  <= '0;
            m_tail  <= '0;
            m_count <= '0;
            m_mis_q <= 1'b0;
            allocs  <= 0;
            retired <= 0;
        end else begin
            m_mis_q <= exp_mispredict;
            if (complete_valid) begin
                m_done[complete_tag] <= 1'b1;
            end
            if (br_update_valid) begin
                m_taken[br_update_tag] <= br_taken;
            end
            if (accept) begin
                allocs <= allocs + 1;
                m_op[m_tail]   <= alloc_op;
                m_pred[m_tail] <= alloc_pred_taken;
                m_done[m_tail] <= 1'b0;
                if (alloc_op inside {OP_SW, OP_SH, OP_SB}) begin
                    m_rd[m_tail] <= alloc_st_src;
                end else begin
                    m_rd[m_tail] <= alloc_rd;
                end
            end
            if (exp_retire) begin
                retired <= retired + 1;
            end
            // wrong branch retires and takes every younger slot with it
            if (exp_mispredict) begin
                m_head  <= m_head + 3'd1;
                m_tail  <= m_head + 3'd1;
                m_count <= '0;
            end else begin
                if (accept) begin
                    m_tail <= m_tail + 3'd1;
                end
                if (exp_retire) begin
                    m_head <= m_head + 3'd1;
                end
                case ({accept, exp_retire})
                    2'b10:   m_count <= m_count + 4'd1;
                    2'b01:   m_count <= m_count - 4'd1;
                    default: m_count <= m_count;
                endcase
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    ready_chk: assert property (@(posedge clk) disable iff (rst) alloc_ready == exp_ready)
        else report_mismatch("alloc_ready", 32'($sampled(alloc_ready)),
                             32'($sampled(exp_ready)));
    tag_chk: assert property (@(posedge clk) disable iff (rst) alloc_ready |-> alloc_tag == m_tail)
        else report_mismatch("alloc_tag", 32'($sampled(alloc_tag)), 32'($sampled(m_tail)));
    load_pulse_chk: assert property (@(posedge clk) disable iff (rst) regfile_load == exp_reg_load)
        else report_mismatch("regfile_load", 32'($sampled(regfile_load)),
                             32'($sampled(exp_reg_load)));
    rd_chk: assert property (@(posedge clk) disable iff (rst)
                             regfile_load |-> rd_commit == m_rd[m_head])
        else report_mismatch("rd_commit", 32'($sampled(rd_commit)),
                             32'($sampled(m_rd[m_head])));
    read_chk: assert property (@(posedge clk) disable iff (rst)
                               data_read == (head_ready && head_is_load))
        else report_mismatch("data_read", 32'($sampled(data_read)),
                             32'($sampled(head_ready && head_is_load)));
    write_chk: assert property (@(posedge clk) disable iff (rst)
                                data_write == (head_ready && head_is_store))
        else report_mismatch("data_write", 32'($sampled(data_write)),
                             32'($sampled(head_ready && head_is_store)));
    // stores follow the byte rule and every other class gives no bytes
    wmask_chk: assert property (@(posedge clk) disable iff (rst) head_ready |-> wmask == exp_wmask)
        else report_mismatch("wmask", 32'($sampled(wmask)), 32'($sampled(exp_wmask)));
    sel_chk: assert property (@(posedge clk) disable iff (rst)
                              ld_commit_sel == (exp_reg_load && head_is_load))
        else report_mismatch("ld_commit_sel", 32'($sampled(ld_commit_sel)),
                             32'($sampled(exp_reg_load && head_is_load)));
    redirect_chk: assert property (@(posedge clk) disable iff (rst) pc_redirect == exp_mispredict)
        else report_mismatch("pc_redirect", 32'($sampled(pc_redirect)),
                             32'($sampled(exp_mispredict)));
    squash_chk: assert property (@(posedge clk) disable iff (rst) m_mis_q |-> squash_busy)
        else report_mismatch("squash_busy", 32'($sampled(squash_busy)), 32'd1);
    // walk only runs on an empty model buffer
    squash_empty_chk: assert property (@(posedge clk) disable iff (rst)
                                       squash_busy |-> m_count == 4'd0)
        else report_mismatch("squash_busy", 32'($sampled(squash_busy)), 32'd0);

    task automatic print_summary();
        $display("allocations %0d, retirements %0d, errors %0d, timeouts %0d",
                 allocs, retired, errors, timeouts);
    endtask

    task automatic record_timeout(input string why);
        timeouts++;
        $display("timeout: %s", why);
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic allocate(input op_t op, input logic pred, output rob_tag_t tag);
        int n;
        n = 0;
        alloc_valid      = 1'b1;
        alloc_op         = op;
        alloc_rd         = 5'(rand_bits(5));
        alloc_st_src     = 5'(rand_bits(5));
        alloc_pred_taken = pred;
        while (!alloc_ready && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (alloc_ready) begin
            tag = alloc_tag;
            next_cycle();
            alloc_valid = 1'b0;
        end else begin
            alloc_valid = 1'b0;
            tag = '0;
            record_timeout("allocation was never accepted");
        end
    endtask

    task automatic mark_done(input rob_tag_t tag);
        complete_valid = 1'b1;
        complete_tag   = tag;
        next_cycle();
        complete_valid = 1'b0;
    endtask

    // outcome and completion arrive together
    task automatic resolve_branch(input rob_tag_t tag, input logic taken);
        br_update_valid = 1'b1;
        br_update_tag   = tag;
        br_taken        = taken;
        complete_valid  = 1'b1;
        complete_tag    = tag;
        next_cycle();
        br_update_valid = 1'b0;
        complete_valid  = 1'b0;
    endtask

    // cache answers some cycles after the request shows up
    task automatic answer_cache(input int delay);
        int n;
        n = 0;
        mem_offset = 2'(rand_bits(2));
        while (!(data_read || data_write) && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (data_read || data_write) begin
            repeat (delay) next_cycle();
            data_mem_resp = 1'b1;
            next_cycle();
            data_mem_resp = 1'b0;
        end else begin
            record_timeout("no data cache request from the head entry");
        end
    endtask

    task automatic do_mem_access(input op_t op);
        rob_tag_t tag;
        allocate(op, 1'b0, tag);
        mark_done(tag);
        answer_cache(int'(rand_bits(2)));
    endtask

    task automatic wait_empty();
        int n;
        n = 0;
        while (m_count != 4'd0 && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (m_count != 4'd0) begin
            record_timeout("buffer did not drain");
        end
    endtask

    task automatic wait_squash();
        int n;
        n = 0;
        while (!squash_busy && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (!squash_busy) begin
            record_timeout("squash walk did not start");
        end else begin
            n = 0;
            while (squash_busy && n < wait_limit) begin
                next_cycle();
                n++;
            end
            if (squash_busy) begin
                record_timeout("squash walk did not finish");
            end
        end
    endtask

    initial begin
        rob_tag_t tags [8];
        rob_tag_t tmp;
        rob_tag_t br_a;
        rob_tag_t br_b;
        logic     pred;
        int       j;
        lfsr             = lfsr_seed;
        rst              = 1'b1;
        alloc_valid      = 1'b0;
        alloc_op         = OP_ALU;
        alloc_rd         = '0;
        alloc_st_src     = '0;
        alloc_pred_taken = 1'b0;
        complete_valid   = 1'b0;
        complete_tag     = '0;
        br_update_valid  = 1'b0;
        br_update_tag    = '0;
        br_taken         = 1'b0;
        data_mem_resp    = 1'b0;
        mem_offset       = 2'b00;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // fill every slot with nothing done yet
        for (int i = 0; i < 8; i++) begin
            allocate(OP_ALU, 1'b0, tags[i]);
        end
        // extra request while full must stall
        alloc_valid = 1'b1;
        repeat (3) next_cycle();
        alloc_valid = 1'b0;
        // complete in shuffled order while retire stays in order
        for (int i = 7; i > 0; i--) begin
            j = int'(rand_bits(3)) % (i + 1);
            tmp = tags[i];
            tags[i] = tags[j];
            tags[j] = tmp;
        end
        for (int i = 0; i < 8; i++) begin
            mark_done(tags[i]);
        end
        wait_empty();

        // stores of every width, then loads
        do_mem_access(OP_SW);
        do_mem_access(OP_SH);
        do_mem_access(OP_SH);
        do_mem_access(OP_SB);
        do_mem_access(OP_SB);
        do_mem_access(OP_LW);
        do_mem_access(OP_LH);
        do_mem_access(OP_LB);
        do_mem_access(OP_LBU);
        do_mem_access(OP_LHU);
        // finished alu op stuck behind a slow load
        allocate(OP_LW, 1'b0, tmp);
        allocate(OP_ALU, 1'b0, tags[0]);
        mark_done(tags[0]);
        mark_done(tmp);
        answer_cache(3);
        wait_empty();

        // two correct branches resolved youngest first
        pred = 1'(rand_bits(1));
        allocate(OP_BRANCH, pred, br_a);
        allocate(OP_BRANCH, !pred, br_b);
        resolve_branch(br_b, !pred);
        resolve_branch(br_a, pred);
        wait_empty();

        // correct branch, then a wrong one with younger alu ops behind
        pred = 1'(rand_bits(1));
        allocate(OP_BRANCH, pred, br_a);
        allocate(OP_BRANCH, pred, br_b);
        for (int i = 0; i < 3; i++) begin
            allocate(OP_ALU, 1'b0, tags[i]);
            mark_done(tags[i]);
        end
        resolve_branch(br_b, !pred);
        resolve_branch(br_a, pred);
        wait_squash();
        // buffer restarts at the slot after the branch
        for (int i = 0; i < 2; i++) begin
            allocate(OP_ALU, 1'b0, tags[i]);
            mark_done(tags[i]);
        end
        wait_empty();

        print_summary();
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic              clk,
    input  logic              rst,
    // allocation
    input  logic              alloc_valid,
    input  isa_pkg::op_t      alloc_op,
    input  rob_pkg::reg_idx_t alloc_rd,
    input  rob_pkg::reg_idx_t alloc_st_src,
    input  logic              alloc_pred_taken,
    output logic              alloc_ready,
    output rob_pkg::rob_tag_t alloc_tag,
    // completion and branch outcome
    input  logic              complete_valid,
    input  rob_pkg::rob_tag_t complete_tag,
    input  logic              br_update_valid,
    input  rob_pkg::rob_tag_t br_update_tag,
    input  logic              br_taken,
    // data cache
    input  logic              data_mem_resp,
    input  logic [1:0]        mem_offset,
    output logic              data_read,
    output logic              data_write,
    output logic [3:0]        wmask,
    // register file and front end
    output logic              regfile_load,
    output logic              ld_commit_sel,
    output rob_pkg::reg_idx_t rd_commit,
    output logic              pc_redirect,
    output logic              squash_busy
);

    import rob_pkg::*;

    // dispatch to table and queue
    logic       wr_en;
    rob_entry_t wr_entry;
    logic       br_enq;
    // table state
    rob_entry_t head_entry;
    rob_tag_t   head_tag;
    rob_tag_t   tail_tag;
    logic       full;
    // branch queue head
    rob_tag_t   oldest_br_tag;
    logic       oldest_br_valid;
    // commit decisions
    logic       retire;
    logic       br_deq;
    logic       mispredict;
    logic       queue_clear;

    rob_dispatch u_dispatch (
        .alloc_valid      (alloc_valid),
        .alloc_op         (alloc_op),
        .alloc_rd         (alloc_rd),
        .alloc_st_src     (alloc_st_src),
        .alloc_pred_taken (alloc_pred_taken),
        .alloc_ready      (alloc_ready),
        .alloc_tag        (alloc_tag),
        .tail_tag         (tail_tag),
        .full             (full),
        .squash_busy      (squash_busy),
        .wr_en            (wr_en),
        .wr_entry         (wr_entry),
        .br_enq           (br_enq)
    );

    // branch tag is the tail slot it was given
    rob_branch_queue u_branch_queue (
        .clk             (clk),
        .rst             (rst),
        .enq             (br_enq),
        .enq_tag         (alloc_tag),
        .deq             (br_deq),
        .clear           (queue_clear),
        .oldest_br_tag   (oldest_br_tag),
        .oldest_br_valid (oldest_br_valid)
    );

    rob_entry_table u_entry_table (
        .clk             (clk),
        .rst             (rst),
        .wr_en           (wr_en),
        .wr_entry        (wr_entry),
        .complete_valid  (complete_valid),
        .complete_tag    (complete_tag),
        .br_update_valid (br_update_valid),
        .br_update_tag   (br_update_tag),
        .br_taken        (br_taken),
        .retire          (retire),
        .mispredict      (mispredict),
        .head_entry      (head_entry),
        .head_tag        (head_tag),
        .tail_tag        (tail_tag),
        .full            (full),
        .squash_busy     (squash_busy)
    );

    rob_commit u_commit (
        .head_entry      (head_entry),
        .head_tag        (head_tag),
        .oldest_br_tag   (oldest_br_tag),
        .oldest_br_valid (oldest_br_valid),
        .squash_busy     (squash_busy),
        .data_mem_resp   (data_mem_resp),
        .mem_offset      (mem_offset),
        .retire          (retire),
        .br_deq          (br_deq),
        .mispredict      (mispredict),
        .pc_redirect     (pc_redirect),
        .data_read       (data_read),
        .data_write      (data_write),
        .wmask           (wmask),
        .regfile_load    (regfile_load),
        .ld_commit_sel   (ld_commit_sel),
        .rd_commit       (rd_commit),
        .queue_clear     (queue_clear)
    );

endmodule

`default_nettype wire

/* hdl/rob_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_commit (
    // head of the buffer
    input  rob_pkg::rob_entry_t head_entry,
    input  rob_pkg::rob_tag_t   head_tag,
    // oldest unresolved branch
    input  rob_pkg::rob_tag_t   oldest_br_tag,
    input  logic                oldest_br_valid,
    input  logic                squash_busy,
    // data cache
    input  logic                data_mem_resp,
    input  logic [1:0]          mem_offset,
    // to table and branch queue
    output logic                retire,
    output logic                br_deq,
    output logic                mispredict,
    output logic                pc_redirect,
    // data cache request
    output logic                data_read,
    output logic                data_write,
    output logic [3:0]          wmask,
    // register file write
    output logic                regfile_load,
    output logic                ld_commit_sel,
    output rob_pkg::reg_idx_t   rd_commit,
    output logic                queue_clear
);

    import isa_pkg::*;

    logic head_ok;
    logic outcome_wrong;
    logic is_oldest_br;

    // head is computed and no squash walk is running
    assign head_ok = head_entry.live && head_entry.done && !squash_busy;

    assign outcome_wrong = (head_entry.taken != head_entry.pred_taken);
    assign is_oldest_br  = oldest_br_valid && (oldest_br_tag == head_tag);

    // register number goes out whatever the class
    assign rd_commit = head_entry.rd;

    always_comb begin
        retire        = 1'b0;
        br_deq        = 1'b0;
        mispredict    = 1'b0;
        data_read     = 1'b0;
        data_write    = 1'b0;
        regfile_load  = 1'b0;
        ld_commit_sel = 1'b0;
        if (head_ok) begin
            if (is_load(head_entry.op)) begin
                // read held until the cache answers
                data_read = 1'b1;
                if (data_mem_resp) begin
                    retire        = 1'b1;
                    regfile_load  = 1'b1;
                    // register file takes cache data
                    ld_commit_sel = 1'b1;
                end
            end else if (is_store(head_entry.op)) begin
                // write held until the cache answers
                data_write = 1'b1;
                retire     = data_mem_resp;
            end else if (head_entry.op == OP_BRANCH) begin
                retire     = 1'b1;
                br_deq     = 1'b1;
                mispredict = is_oldest_br && outcome_wrong;
            end else begin
                // alu result straight into the register file
                retire       = 1'b1;
                regfile_load = 1'b1;
            end
        end
    end

    // redirect lasts one cycle and empties the branch queue
    assign pc_redirect = mispredict;
    assign queue_clear = mispredict;

    // byte enables for the store at the head
    always_comb begin
        case (head_entry.op)
            OP_SW:   wmask = 4'b1111;
            OP_SH:   wmask = 4'b0011 << mem_offset;
            OP_SB:   wmask = 4'b0001 << mem_offset;
            default: wmask = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rob_entry_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_entry_table (
    input  logic                clk,
    input  logic                rst,
    // allocation at the tail
    input  logic                wr_en,
    input  rob_pkg::rob_entry_t wr_entry,
    // result produced for a tag
    input  logic                complete_valid,
    input  rob_pkg::rob_tag_t   complete_tag,
    // branch outcome for a tag
    input  logic                br_update_valid,
    input  rob_pkg::rob_tag_t   br_update_tag,
    input  logic                br_taken,
    // from commit
    input  logic                retire,
    input  logic                mispredict,
    // state seen by commit and dispatch
    output rob_pkg::rob_entry_t head_entry,
    output rob_pkg::rob_tag_t   head_tag,
    output rob_pkg::rob_tag_t   tail_tag,
    output logic                full,
    output logic                squash_busy
);

    import rob_pkg::*;

    localparam int cnt_w = `ROB_TAG_W + 1;

    rob_entry_t       entries [`ROB_DEPTH];
    rob_tag_t         head;
    rob_tag_t         tail;
    logic [cnt_w-1:0] count;
    // next younger slot to clear during a squash
    rob_tag_t         walk_ptr;
    logic             squash_q;

    assign head_entry  = entries[head];
    assign head_tag    = head;
    assign tail_tag    = tail;
    assign squash_busy = squash_q;

    // full means every slot is live
    assign full = (count == cnt_w'(`ROB_DEPTH));

    // entry contents and live/done flags
    always_ff @(posedge clk) begin
        if (rst) begin
            // every slot starts empty
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i].live <= 1'b0;
                entries[i].done <= 1'b0;
            end
        end else begin
            // late results for squashed slots are dropped
            if (complete_valid && entries[complete_tag].live) begin
                entries[complete_tag].done <= 1'b1;
            end
            if (br_update_valid && entries[br_update_tag].live) begin
                entries[br_update_tag].taken <= br_taken;
            end
            // fresh entry overrides any stale update to that slot
            if (wr_en) begin
                entries[tail] <= wr_entry;
            end
            if (retire) begin
                entries[head].live <= 1'b0;
            end
            // walk clears one younger slot per cycle
            if (squash_q && walk_ptr != tail) begin
                entries[walk_ptr].live <= 1'b0;
            end
        end
    end

    // pointers, count and the squash walk
    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            walk_ptr <= '0;
            squash_q <= 1'b0;
        end else begin
            if (wr_en) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({wr_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // mispredicted branch retires now and the walk starts one past it
            if (mispredict) begin
                squash_q <= 1'b1;
                walk_ptr <= head + 1'b1;
            end else if (squash_q) begin
                if (walk_ptr == tail) begin
                    // nothing younger left so the buffer is empty
                    tail     <= head;
                    count    <= '0;
                    squash_q <= 1'b0;
                end else begin
                    walk_ptr <= walk_ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rob_branch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_branch_queue (
    input  logic              clk,
    input  logic              rst,
    // push tag of a newly allocated branch
    input  logic              enq,
    input  rob_pkg::rob_tag_t enq_tag,
    // pop when the oldest branch retires
    input  logic              deq,
    // drop everything on a mispredict
    input  logic              clear,
    output rob_pkg::rob_tag_t oldest_br_tag,
    output logic              oldest_br_valid
);

    import rob_pkg::*;

    localparam int cnt_w = `ROB_TAG_W + 1;

    // branch tags in program order
    rob_tag_t        tags [`ROB_DEPTH];
    rob_tag_t        rd_ptr;
    rob_tag_t        wr_ptr;
    logic [cnt_w-1:0] count;

    // head of queue is the oldest unresolved branch
    assign oldest_br_tag   = tags[rd_ptr];
    assign oldest_br_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (enq) begin
            tags[wr_ptr] <= enq_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // only pop a real element
            if (deq && oldest_br_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy follows push and pop
            case ({enq, deq && oldest_br_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/rob_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_dispatch (
    // allocation handshake
    input  logic               alloc_valid,
    input  isa_pkg::op_t       alloc_op,
    input  rob_pkg::reg_idx_t  alloc_rd,
    input  rob_pkg::reg_idx_t  alloc_st_src,
    input  logic               alloc_pred_taken,
    output logic               alloc_ready,
    output rob_pkg::rob_tag_t  alloc_tag,
    // table state
    input  rob_pkg::rob_tag_t  tail_tag,
    input  logic               full,
    input  logic               squash_busy,
    // to table and branch queue
    output logic               wr_en,
    output rob_pkg::rob_entry_t wr_entry,
    output logic               br_enq
);

    import isa_pkg::*;

    logic is_branch;

    // no room, or a squash walk still moving the tail
    assign alloc_ready = !full && !squash_busy;

    // new entry always lands at the tail
    assign alloc_tag = tail_tag;

    // transfer on valid and ready in the same cycle
    assign wr_en = alloc_valid && alloc_ready;

    assign is_branch = (alloc_op == OP_BRANCH);

    // branches also go into the in-order branch queue
    assign br_enq = wr_en && is_branch;

    always_comb begin
        wr_entry.op = alloc_op;
        // stores carry their data source instead of a destination
        if (is_store(alloc_op)) begin
            wr_entry.rd = alloc_st_src;
        end else begin
            wr_entry.rd = alloc_rd;
        end
        // prediction only means something for branches
        wr_entry.pred_taken = is_branch && alloc_pred_taken;
        // outcome unknown until the branch unit reports
        wr_entry.taken = 1'b0;
        // nothing computed yet
        wr_entry.done = 1'b0;
        wr_entry.live = 1'b1;
    end

endmodule

`default_nettype wire

/* hdl/rob_pkg.sv */
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

    // index of an entry in the buffer
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // architectural register number
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // one buffer slot
    // rd holds the store data source for stores
    typedef struct packed {
        // instruction class
        isa_pkg::op_t op;
        // destination, or store source register
        reg_idx_t     rd;
        // front end guess for branches
        logic         pred_taken;
        // resolved outcome for branches
        logic         taken;
        // result has been produced
        logic         done;
        // slot holds an allocated instruction
        logic         live;
    } rob_entry_t;

endpackage

`default_nettype wire

/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // instruction class as seen by the rob
    // stores and loads grouped so the classes stay contiguous
    typedef enum logic [3:0] {
        OP_ALU,
        OP_BRANCH,
        OP_SW,
        OP_SH,
        OP_SB,
        OP_LW,
        OP_LH,
        OP_LB,
        OP_LBU,
        OP_LHU
    } op_t;

    // any load width, signed or unsigned
    function automatic logic is_load(input op_t op);
        return op inside {OP_LW, OP_LH, OP_LB, OP_LBU, OP_LHU};
    endfunction

    // word, half or byte store
    function automatic logic is_store(input op_t op);
        return op inside {OP_SW, OP_SH, OP_SB};
    endfunction

endpackage

`default_nettype wire

/* hdl/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// reorder buffer sizing

// number of in-flight entries
`define ROB_DEPTH 8

// bits needed to index an entry
`define ROB_TAG_W 3

// architectural register index for x0 to x31
`define REG_IDX_W 5

// ROB_DEPTH must stay a power of two
// so pointers wrap on their own
`endif
